// File: logic/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath width
`define XLEN            64

// machine CSR addresses handled by the execute unit
`define CSR_MSTATUS     12'd768
`define CSR_MTVEC       12'd773
`define CSR_MEPC        12'd833
`define CSR_MCAUSE      12'd834

// environment call from M-mode
`define MCAUSE_ECALL_M  64'd11

// result queue entries, also the issue credits upstream starts with
`define RQ_DEPTH        4
// credits granted by the writeback consumer at reset
`define WB_CREDITS      2

`endif

// File: logic/exec_pkg.sv
`include "exec_params.svh"

package exec_pkg;

    // ALU operation, 4 bits
    typedef enum logic [3:0] {
        alu_add     = 4'd0,
        alu_sub     = 4'd1,
        alu_and     = 4'd2,
        alu_or      = 4'd3,
        alu_xor     = 4'd4,
        alu_sll     = 4'd5,
        alu_srl     = 4'd6,
        alu_sra     = 4'd7,
        alu_slt     = 4'd8,
        alu_sltu    = 4'd9,
        alu_csr_set = 4'd10, // csrrs / csrrsi
        alu_ecall   = 4'd11
    } alu_op_e;

    // ALU source pair selection, code 7 is not defined
    typedef enum logic [2:0] {
        sel_reg     = 3'd0,
        sel_imm     = 3'd1,
        sel_four_pc = 3'd2,
        sel_imm_pc  = 3'd3,
        sel_csrrs   = 3'd4,
        sel_csrrsi  = 3'd5,
        sel_ecall   = 3'd6
    } src_sel_e;

    typedef struct packed {
        logic              valid;    // filled in by the top from issue_valid
        alu_op_e           op;
        src_sel_e          src_sel;
        logic [`XLEN-1:0]  rs1_data;
        logic [`XLEN-1:0]  rs2_data;
        logic [`XLEN-1:0]  imm;
        logic [`XLEN-1:0]  pc;
        logic [11:0]       csr_addr;
        logic              hazard;   // forces src2 to zero
    } issue_pkt_t;

    typedef struct packed {
        logic [`XLEN-1:0]  src1;
        logic [`XLEN-1:0]  src2;
    } operands_t;

    // ecall_we writes data to mepc and the ecall cause to mcause
    typedef struct packed {
        logic              we;
        logic              ecall_we;
        logic [11:0]       addr;
        logic [`XLEN-1:0]  data;
    } csr_wr_t;

    typedef struct packed {
        logic [`XLEN-1:0]  data;
        logic              trap;
    } result_t;

endpackage

// File: logic/operand_select.sv
`include "exec_params.svh"

module operand_select (
    input  exec_pkg::issue_pkt_t issue,
    input  logic [`XLEN-1:0]     csr_rdata, // value of the CSR at issue.csr_addr
    output exec_pkg::operands_t  ops
);

    import exec_pkg::*;

    always_comb begin
        ops.src1 = issue.rs1_data; // default is the register pair
        ops.src2 = issue.rs2_data;
        if (issue.hazard) begin
            ops.src2 = '0; // hazard overrides the select code
        end else begin
            case (issue.src_sel)
                sel_reg: begin
                    ops.src2 = issue.rs2_data;
                end
                sel_imm: begin
                    ops.src2 = issue.imm;
                end
                sel_four_pc: begin
                    ops.src1 = `XLEN'd4; // pc + 4
                    ops.src2 = issue.pc;
                end
                sel_imm_pc: begin
                    ops.src1 = issue.imm; // pc + imm
                    ops.src2 = issue.pc;
                end
                sel_csrrs: begin
                    ops.src1 = issue.rs1_data; // set mask from register
                    ops.src2 = csr_rdata;      // old csr value
                end
                sel_csrrsi: begin
                    ops.src1 = issue.imm; // zimm already in imm
                    ops.src2 = csr_rdata;
                end
                sel_ecall: begin
                    ops.src1 = issue.pc;
                    ops.src2 = issue.pc;
                end
                default: begin
                    ops.src1 = issue.rs1_data;
                    ops.src2 = issue.rs2_data;
                end
            endcase
        end
    end

    // select code must be defined for a valid packet
    always_comb begin
        if (issue.valid) begin
            src_sel_known_a: assert (issue.src_sel inside {sel_reg, sel_imm, sel_four_pc,
                                                           sel_imm_pc, sel_csrrs, sel_csrrsi,
                                                           sel_ecall})
                else $error("operand_select: undefined src_sel %0d", issue.src_sel);
        end
    end

endmodule

// File: logic/csr_file.sv
`include "exec_params.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [11:0]          rd_addr,
    output logic [`XLEN-1:0]     rdata,
    input  exec_pkg::csr_wr_t    wr
);

    logic [`XLEN-1:0] mstatus;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;

    always_comb begin
        case (rd_addr)
            `CSR_MSTATUS: rdata = mstatus;
            `CSR_MTVEC:   rdata = mtvec;
            `CSR_MEPC:    rdata = mepc;
            `CSR_MCAUSE:  rdata = mcause;
            default:      rdata = '0; // unknown csr reads zero
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (wr.ecall_we) begin
            mepc   <= wr.data; // trapping pc
            mcause <= `MCAUSE_ECALL_M;
        end else if (wr.we) begin
            case (wr.addr)
                `CSR_MSTATUS: mstatus <= wr.data;
                `CSR_MTVEC:   mtvec   <= wr.data;
                `CSR_MEPC:    mepc    <= wr.data;
                `CSR_MCAUSE:  mcause  <= wr.data;
                default:      ; // dropped
            endcase
        end
    end

    // the alu filters out writes to addresses not held here
    csr_wr_known_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr.we |-> (wr.addr inside {`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE})
    ) else $error("csr_file: write to unknown csr address %0d", wr.addr);

endmodule

// File: logic/alu.sv
`include "exec_params.svh"

module alu (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  exec_pkg::alu_op_e    op,
    input  logic [11:0]          csr_addr,
    input  exec_pkg::operands_t  ops,
    output exec_pkg::csr_wr_t    csr_wr,
    output logic                 wb_valid,
    output exec_pkg::result_t    wb_result
);

    import exec_pkg::*;

    logic [5:0]       shamt;
    logic [`XLEN-1:0] res_d;
    logic             trap_d;
    logic             csr_known;

    assign shamt     = ops.src2[5:0]; // rv64 shift amount
    assign csr_known = csr_addr inside {`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE};

    always_comb begin
        trap_d = 1'b0;
        case (op)
            alu_add:     res_d = ops.src1 + ops.src2;
            alu_sub:     res_d = ops.src1 - ops.src2;
            alu_and:     res_d = ops.src1 & ops.src2;
            alu_or:      res_d = ops.src1 | ops.src2;
            alu_xor:     res_d = ops.src1 ^ ops.src2;
            alu_sll:     res_d = ops.src1 << shamt;
            alu_srl:     res_d = ops.src1 >> shamt;
            alu_sra:     res_d = $signed(ops.src1) >>> shamt;
            alu_slt:     res_d = `XLEN'($signed(ops.src1) < $signed(ops.src2));
            alu_sltu:    res_d = `XLEN'(ops.src1 < ops.src2);
            alu_csr_set: res_d = ops.src2; // old csr value
            alu_ecall: begin
                res_d  = ops.src1; // pc of the ecall
                trap_d = 1'b1;
            end
            default:     res_d = '0;
        endcase
    end

    // csr side effects land on the same edge as the result register
    always_comb begin
        csr_wr.we       = in_valid && (op == alu_csr_set) && csr_known;
        csr_wr.ecall_we = in_valid && (op == alu_ecall);
        if (op == alu_ecall) begin
            csr_wr.addr = `CSR_MEPC;
            csr_wr.data = ops.src1;
        end else begin
            csr_wr.addr = csr_addr;
            csr_wr.data = ops.src1 | ops.src2; // set bits into old value
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            wb_result.data <= res_d;
            wb_result.trap <= trap_d;
        end
    end

endmodule

// File: logic/result_queue.sv
`include "exec_params.svh"

module result_queue (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wb_valid,
    input  exec_pkg::result_t    wb_result,
    input  logic                 result_credit,
    output logic                 result_valid,
    output exec_pkg::result_t    result,
    output logic                 issue_credit
);

    import exec_pkg::*;

    result_t                           mem [`RQ_DEPTH];
    logic [$clog2(`RQ_DEPTH)-1:0]      wr_ptr;
    logic [$clog2(`RQ_DEPTH)-1:0]      rd_ptr;
    logic [$clog2(`RQ_DEPTH):0]        count;
    logic [$clog2(`WB_CREDITS):0]      wb_cnt;   // writeback credits held
    logic                              full;
    logic                              empty;
    logic                              pop;

    assign full  = (count == `RQ_DEPTH);
    assign empty = (count == '0);
    assign pop   = !empty && (wb_cnt != '0); // need an entry and a credit

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            mem[wr_ptr] <= wb_result;
        end
        if (pop) begin
            result <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            wb_cnt       <= `WB_CREDITS;
            result_valid <= 1'b0;
            issue_credit <= 1'b0;
        end else begin
            if (wb_valid) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wb_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({pop, result_credit})
                2'b10:   wb_cnt <= wb_cnt - 1'b1;
                2'b01:   wb_cnt <= wb_cnt + 1'b1;
                default: wb_cnt <= wb_cnt; // spend and return cancel
            endcase
            result_valid <= pop;
            issue_credit <= pop; // entry freed, upstream may issue again
        end
    end

    // upstream credits cover the pipeline as well as the queue
    rq_no_overflow_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_valid |-> !full
    ) else $error("result_queue: write while full");

    rq_wb_credit_max_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_cnt <= `WB_CREDITS
    ) else $error("result_queue: writeback credits above grant, %0d", wb_cnt);

endmodule

// File: logic/exec_unit.sv
`include "exec_params.svh"

module exec_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 issue_valid,
    input  exec_pkg::issue_pkt_t issue,
    output logic                 issue_credit,
    output logic                 result_valid,
    output exec_pkg::result_t    result,
    input  logic                 result_credit
);

    import exec_pkg::*;

    issue_pkt_t       issue_q;   // packet with its valid bit taken from issue_valid
    operands_t        ops;
    csr_wr_t          csr_wr;
    logic [`XLEN-1:0] csr_rdata;
    logic             wb_valid;
    result_t          wb_result;

    always_comb begin
        issue_q       = issue;
        issue_q.valid = issue_valid;
    end

    operand_select u_operand_select (
        .issue      (issue_q),
        .csr_rdata  (csr_rdata),
        .ops        (ops)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .arst_n     (arst_n),
        .rd_addr    (issue_q.csr_addr),
        .rdata      (csr_rdata),
        .wr         (csr_wr)
    );

    alu u_alu (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (issue_q.valid),
        .op         (issue_q.op),
        .csr_addr   (issue_q.csr_addr),
        .ops        (ops),
        .csr_wr     (csr_wr),
        .wb_valid   (wb_valid),
        .wb_result  (wb_result)
    );

    result_queue u_result_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .wb_valid      (wb_valid),
        .wb_result     (wb_result),
        .result_credit (result_credit),
        .result_valid  (result_valid),
        .result        (result),
        .issue_credit  (issue_credit)
    );

endmodule

// File: tests/exec_unit_tb.sv
`include "exec_params.svh"

module exec_unit_tb;

    import exec_pkg::*;

    localparam int FIELDS   = 11; // columns per packet line
    localparam int MAX_PKTS = 64;

    logic       clk;
    logic       arst_n;
    logic       issue_valid;
    issue_pkt_t issue;
    logic       issue_credit;
    logic       result_valid;
    result_t    result;
    logic       result_credit;

    logic [63:0] stim [FIELDS*MAX_PKTS];
    int num_pkts;
    int pkt_idx;
    int seed;
    int issue_credits;  // upstream credits held
    int owed;           // writeback credits still to hand back
    int returned;
    int results_seen;
    int withhold;       // cycles left with result_credit held low
    int cycles;
    int timeout_limit;

    exec_unit UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_credit  (issue_credit),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit)
    );

    always #5 clk = ~clk;

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("** FAIL **");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    function automatic issue_pkt_t pkt_from_file(input int p);
        issue_pkt_t pkt;
        int base;
        base         = p * FIELDS;
        pkt          = '0;
        pkt.op       = alu_op_e'(stim[base][3:0]);
        pkt.src_sel  = src_sel_e'(stim[base+1][2:0]);
        pkt.rs1_data = stim[base+2];
        pkt.rs2_data = stim[base+3];
        pkt.imm      = stim[base+4];
        pkt.pc       = stim[base+5];
        pkt.csr_addr = stim[base+6][11:0];
        pkt.hazard   = stim[base+7][0];
        return pkt;
    endfunction

    // credits to keep so a chain of back-to-back packets issues without a gap
    function automatic int credits_needed(input int p);
        int need;
        int j;
        need = 1;
        j    = p + 1;
        while (j < num_pkts && stim[j*FIELDS+8] != 0) begin
            need++;
            j++;
        end
        return need;
    endfunction

    task automatic return_wb_credit();
        result_credit = 1'b0;
        if (withhold > 0) begin
            withhold--;
        end else if (($random(seed) & 15) == 0) begin
            withhold = 12 + (($random(seed) & 32'h7fffffff) % 16); // long back-pressure
        end else if (owed > 0 && ($random(seed) & 1) != 0) begin
            result_credit = 1'b1;
            owed--;
            returned++;
        end
    endtask

    task automatic try_issue();
        logic go;
        issue_valid = 1'b0;
        if (pkt_idx < num_pkts) begin
            go = (stim[pkt_idx*FIELDS+8] != 0) || (($random(seed) & 3) != 0);
            if (go && issue_credits >= credits_needed(pkt_idx)) begin
                issue         = pkt_from_file(pkt_idx);
                issue_valid   = 1'b1;
                issue_credits--;
                pkt_idx++;
            end
        end
    endtask

    task automatic run_all();
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (4) begin  // nothing may come out before the first packet
            @(posedge clk);
            #1;
            check(64'(result_valid), 64'd0, "result_valid after reset");
            check(64'(issue_credit), 64'd0, "issue_credit after reset");
        end
        while (results_seen < num_pkts) begin
            @(posedge clk);
            #1;
            return_wb_credit();
            try_issue();
        end
        repeat (8) begin
            @(posedge clk);
            #1;
            return_wb_credit();
        end
    endtask

    // outputs sampled mid-cycle, away from the edges
    always @(negedge clk) begin
        if (arst_n) begin
            check(64'(issue_credit), 64'(result_valid), "issue_credit pulse against pop");
            if (issue_credit) begin
                issue_credits++;
            end
            if (result_valid) begin
                if (results_seen >= num_pkts) begin
                    $display("a result came out after the last packet was already returned");
                    $display("** FAIL **");
                    $fatal(1, "extra result");
                end else begin
                    check(64'(results_seen < `WB_CREDITS + returned), 64'd1,
                          "result popped without a writeback credit");
                    check(result.data, stim[results_seen*FIELDS+9],
                          $sformatf("packet %0d data", results_seen));
                    check(64'(result.trap), stim[results_seen*FIELDS+10],
                          $sformatf("packet %0d trap", results_seen));
                    results_seen++;
                    owed++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycles++;
            if (cycles > timeout_limit) begin
                $display("timeout after %0d cycles, only %0d of %0d results arrived", cycles,
                         results_seen, num_pkts);
                $display("** FAIL **");
                $fatal(1, "simulation timed out");
            end
        end
    end

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        issue_valid   = 1'b0;
        issue         = '0;
        result_credit = 1'b0;
        seed          = 32'h0f414ed9;
        issue_credits = `RQ_DEPTH;
        owed          = 0;
        returned      = 0;
        results_seen  = 0;
        withhold      = 0;
        cycles        = 0;
        pkt_idx       = 0;
        $readmemh("tests/exec_stimulus.txt", stim);
        num_pkts = 0;
        while (num_pkts < MAX_PKTS && stim[num_pkts*FIELDS] != 64'hf) begin
            num_pkts++; // op f marks the end
        end
        timeout_limit = 20 * num_pkts + 100;
        if (num_pkts == 0) begin
            $display("no packets were read from the stimulus file");
            $display("** FAIL **");
            $fatal(1, "empty stimulus");
        end else begin
            run_all();
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: tb.f
+incdir+logic
logic/exec_pkg.sv
logic/operand_select.sv
logic/csr_file.sv
logic/alu.sv
logic/result_queue.sv
logic/exec_unit.sv
tests/exec_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the exec_unit testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 -f tb.f --top-module exec_unit_tb -o exec_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/exec_unit_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "simulation finished without failures"
exit 0

// File: tests/exec_stimulus.txt
// op sel rs1 rs2 imm pc csr_addr hazard back_to_back, then expected data and expected trap
// all columns hex, one packet per line, op f ends the list
0 0 5 7 0 0 0 0 0 c 0
1 0 3 5 0 0 0 0 0 fffffffffffffffe 0
2 0 ff00ff00 0ff00ff0 0 0 0 0 0 0f000f00 0
3 0 f0 0f 0 0 0 0 0 ff 0
4 0 ffff 0f0f 0 0 0 0 0 f0f0 0
0 1 100 0 fffffffffffffff0 0 0 0 0 f0 0
5 1 1 0 3f 0 0 0 0 8000000000000000 0
5 0 3 44 0 0 0 0 0 30 0
6 0 8000000000000000 3f 0 0 0 0 0 1 0
7 1 8000000000000000 0 4 0 0 0 0 f800000000000000 0
8 0 ffffffffffffffff 1 0 0 0 0 0 1 0
9 0 ffffffffffffffff 1 0 0 0 0 0 0 0
8 1 5 0 fffffffffffffffb 0 0 0 0 0 0
9 1 5 0 fffffffffffffffb 0 0 0 0 1 0
0 2 0 0 0 80000000 0 0 0 80000004 0
0 3 0 0 100 80000010 0 0 0 80000110 0
0 3 0 0 fffffffffffffff8 80000020 0 0 0 80000018 0
0 0 10 99 0 0 0 1 0 10 0
1 1 20 0 5 0 0 1 0 20 0
7 0 f0 4 0 0 0 1 0 f0 0
a 4 8 0 0 0 300 0 0 0 0
a 5 0 0 3 0 300 0 1 8 0
a 4 0 0 0 0 300 0 1 b 0
a 5 0 0 10 0 305 0 0 0 0
a 4 f00 0 0 0 305 0 0 10 0
a 4 0 0 0 0 305 0 0 f10 0
b 6 0 0 0 80000040 0 0 0 80000040 1
a 4 0 0 0 0 341 0 1 80000040 0
a 4 0 0 0 0 342 0 0 b 0
a 4 ff 0 0 0 7c0 0 0 0 0
a 4 0 0 0 0 7c0 0 0 0 0
a 5 0 0 4 0 342 0 0 b 0
a 4 0 0 0 0 342 0 1 f 0
0 0 123456789abcdef0 0fedcba987654321 0 0 0 0 0 2222222222222211 0
6 1 ffffffffffffffff 0 3c 0 0 0 0 f 0
b 6 0 0 0 80000100 0 0 0 80000100 1
a 4 1 0 0 0 341 0 0 80000100 0
a 4 0 0 0 0 341 0 1 80000101 0
a 4 0 0 0 0 342 0 0 b 0
f 0 0 0 0 0 0 0 0 0 0
